// ==== copper_pkg.sv ====
`default_nettype none

package copper_pkg;

	// Widths with a meaning of their own
	typedef logic [11:0] reg_addr_t;
	typedef logic [15:0] word_t;
	typedef logic [9:0]  coord_t;
	typedef logic [11:0] color_t;
	typedef logic [8:0]  list_pc_t;

	// Raster sizes, small so that a frame is short in simulation
	localparam coord_t H_TOTAL = 10'd40;
	localparam coord_t V_TOTAL = 10'd30;

	localparam int LIST_WORDS = 512;

	// Register map
	localparam reg_addr_t REG_COPPER_EN = 12'hD20;
	localparam reg_addr_t REG_VFLIP     = 12'hD21;
	localparam reg_addr_t REG_BG_COLOR  = 12'hD22;
	localparam reg_addr_t REG_PAN_X     = 12'hD23;
	localparam reg_addr_t REG_PAN_Y     = 12'hD24;
	// List window spans 400 to 5FF
	localparam reg_addr_t LIST_BASE     = 12'h400;

	localparam color_t BG_RESET_COLOR = 12'hF00;

	// Opcode in bits 15:12 of a list word, other codes are no-ops
	typedef enum logic [3:0] {
		OP_JUMP       = 4'd1,
		OP_WAIT_V     = 4'd2,
		OP_WAIT_H     = 4'd3,
		OP_SKIP_V     = 4'd4,
		OP_SKIP_H     = 4'd5,
		OP_SET_BG     = 4'd6,
		OP_WAIT_V_REL = 4'd7,
		OP_WAIT_H_REL = 4'd8,
		OP_WRITE_REG  = 4'd9
	} copper_op_e;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		EXECUTE,
		WAIT_V,
		WAIT_H,
		WRITE_DATA
	} copper_state_e;

endpackage

`default_nettype wire

// ==== raster_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Beam position and line and frame ticks
interface raster_if import copper_pkg::*; ();

	coord_t x;
	coord_t y;
	logic   line_tick;
	logic   frame_tick;

	modport source (
		output x, y, line_tick, frame_tick
	);

	modport sink (
		input x, y, line_tick, frame_tick
	);

endinterface

`default_nettype wire

// ==== raster_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_timer import copper_pkg::*; (
	input wire CLK,
	input wire RSTb,
	raster_if.source rif
);

	coord_t x_next;
	coord_t y_next;

	always_comb begin
		x_next = (rif.x == H_TOTAL - 10'd1) ? '0 : rif.x + 10'd1;
		y_next = rif.y;
		// Line advances when x wraps
		if (x_next == '0) begin
			y_next = (rif.y == V_TOTAL - 10'd1) ? '0 : rif.y + 10'd1;
		end
	end

	// Ticks decoded from the next position so they line up with the counters
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			rif.x          <= '0;
			rif.y          <= '0;
			// Beam sits at the frame origin, so the first cycle out of reset is a frame start
			rif.line_tick  <= 1'b1;
			rif.frame_tick <= 1'b1;
		end else begin
			rif.x          <= x_next;
			rif.y          <= y_next;
			rif.line_tick  <= (x_next == '0);
			rif.frame_tick <= (x_next == '0) && (y_next == '0);
		end
	end

endmodule

`default_nettype wire

// ==== copper_list_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module copper_list_ram import copper_pkg::*; (
	input  wire           CLK,
	input  wire list_pc_t raddr,
	output word_t         rdata,
	input  wire           we,
	input  wire list_pc_t waddr,
	input  wire word_t    wdata
);

	word_t mem [LIST_WORDS];

	// Read-first, a write to the read address shows up a cycle later
	always_ff @(posedge CLK) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// ==== copper_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module copper_seq import copper_pkg::*; (
	input  wire            CLK,
	input  wire            RSTb,
	raster_if.sink         rif,
	input  wire            copper_en,
	output list_pc_t       pc,
	input  wire word_t     ins,
	output logic           cop_we,
	output reg_addr_t      cop_addr,
	output word_t          cop_data,
	output logic           bg_we,
	output color_t         bg_color
);

	copper_state_e state;
	coord_t        wait_target;
	// Set while the data word of a register write is being fetched
	logic          wr_pending;

	copper_op_e    op;
	coord_t        operand;

	assign op      = copper_op_e'(ins[15:12]);
	assign operand = ins[9:0];

	// Color goes out in the execute cycle, frame start takes precedence
	assign bg_we    = (state == EXECUTE) && (op == OP_SET_BG) && !rif.frame_tick;
	assign bg_color = ins[11:0];

	always_ff @(posedge CLK) begin
		cop_we <= 1'b0;
		if (!RSTb) begin
			state       <= IDLE;
			pc          <= '0;
			wait_target <= '0;
			wr_pending  <= 1'b0;
		end else if (rif.frame_tick) begin
			// Restart the list every frame
			state      <= FETCH;
			pc         <= '0;
			wr_pending <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					state <= IDLE;
				end

				// RAM output is valid in the cycle after this one
				FETCH: begin
					if (copper_en) begin
						state <= wr_pending ? WRITE_DATA : EXECUTE;
					end
				end

				EXECUTE: begin
					state <= FETCH;
					case (op)
						OP_JUMP: begin
							pc <= ins[8:0];
						end
						OP_WAIT_V: begin
							wait_target <= operand;
							state       <= WAIT_V;
						end
						OP_WAIT_H: begin
							wait_target <= operand;
							state       <= WAIT_H;
						end
						OP_SKIP_V: begin
							pc <= pc + ((rif.y >= operand) ? list_pc_t'(2) : list_pc_t'(1));
						end
						OP_SKIP_H: begin
							pc <= pc + ((rif.x >= operand) ? list_pc_t'(2) : list_pc_t'(1));
						end
						// Hold off until the next line, a frame end also releases it
						OP_SET_BG: begin
							wait_target <= rif.y + 10'd1;
							state       <= WAIT_V;
						end
						OP_WAIT_V_REL: begin
							wait_target <= rif.y + operand;
							state       <= WAIT_V;
						end
						OP_WAIT_H_REL: begin
							wait_target <= rif.x + operand;
							state       <= WAIT_H;
						end
						OP_WRITE_REG: begin
							cop_addr   <= ins[11:0];
							wr_pending <= 1'b1;
							pc         <= pc + list_pc_t'(1);
						end
						default: begin
							pc <= pc + list_pc_t'(1);
						end
					endcase
				end

				WAIT_V: begin
					if (rif.y >= wait_target) begin
						pc    <= pc + list_pc_t'(1);
						state <= FETCH;
					end
				end

				WAIT_H: begin
					if (rif.x >= wait_target) begin
						pc    <= pc + list_pc_t'(1);
						state <= FETCH;
					end
				end

				// Data word of OP_WRITE_REG is on ins now
				WRITE_DATA: begin
					cop_data   <= ins;
					cop_we     <= 1'b1;
					wr_pending <= 1'b0;
					pc         <= pc + list_pc_t'(1);
					state      <= FETCH;
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== gfx_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module gfx_regs import copper_pkg::*; (
	input  wire            CLK,
	input  wire            RSTb,
	input  wire            wb_cyc,
	input  wire            wb_stb,
	input  wire            wb_we,
	input  wire reg_addr_t wb_adr,
	input  wire word_t     wb_dat_w,
	output word_t          wb_dat_r,
	output logic           wb_ack,
	output logic           list_we,
	output list_pc_t       list_waddr,
	output word_t          list_wdata,
	input  wire            cop_we,
	input  wire reg_addr_t cop_addr,
	input  wire word_t     cop_data,
	input  wire            bg_we,
	input  wire color_t    bg_color_in,
	raster_if.sink         rif,
	output logic           copper_en,
	output color_t         background_color,
	output coord_t         display_x_out,
	output coord_t         display_y_out
);

	logic   vflip;
	coord_t pan_x;
	coord_t pan_y;
	logic   host_wr;
	coord_t y_src;

	// Host write takes effect in the ack cycle
	assign host_wr    = wb_cyc && wb_stb && wb_we && wb_ack;
	assign list_we    = host_wr && (wb_adr[11:9] == LIST_BASE[11:9]);
	assign list_waddr = wb_adr[8:0];
	assign list_wdata = wb_dat_w;

	function automatic logic wr_hit(input reg_addr_t r);
		return (cop_we && cop_addr == r) || (host_wr && wb_adr == r);
	endfunction

	// Copper beats the host on the same register
	function automatic word_t wr_data(input reg_addr_t r);
		return (cop_we && cop_addr == r) ? cop_data : wb_dat_w;
	endfunction

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= wb_cyc && wb_stb && !wb_ack;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			copper_en        <= 1'b0;
			vflip            <= 1'b0;
			background_color <= BG_RESET_COLOR;
			pan_x            <= '0;
			pan_y            <= '0;
		end else begin
			if (wr_hit(REG_COPPER_EN))
				copper_en <= 1'(wr_data(REG_COPPER_EN));
			if (wr_hit(REG_VFLIP))
				vflip <= 1'(wr_data(REG_VFLIP));
			// SET_BG from the copper overrides either bus write
			if (bg_we)
				background_color <= bg_color_in;
			else if (wr_hit(REG_BG_COLOR))
				background_color <= color_t'(wr_data(REG_BG_COLOR));
			if (wr_hit(REG_PAN_X))
				pan_x <= coord_t'(wr_data(REG_PAN_X));
			if (wr_hit(REG_PAN_Y))
				pan_y <= coord_t'(wr_data(REG_PAN_Y));
		end
	end

	// List window and unmapped addresses read as zero
	always_comb begin
		case (wb_adr)
			REG_COPPER_EN: wb_dat_r = word_t'(copper_en);
			REG_VFLIP:     wb_dat_r = word_t'(vflip);
			REG_BG_COLOR:  wb_dat_r = word_t'(background_color);
			REG_PAN_X:     wb_dat_r = word_t'(pan_x);
			REG_PAN_Y:     wb_dat_r = word_t'(pan_y);
			default:       wb_dat_r = '0;
		endcase
	end

	assign y_src = vflip ? (V_TOTAL - 10'd1 - rif.y) : rif.y;

	// Coordinates wrap modulo 1024, y only moves at line start
	always_ff @(posedge CLK) begin
		display_x_out <= rif.x + pan_x;
		if (rif.line_tick) begin
			display_y_out <= y_src + pan_y;
		end
	end

endmodule

`default_nettype wire

// ==== gfx_copper_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gfx_copper_top import copper_pkg::*; (
	input  wire            CLK,
	input  wire            RSTb,
	input  wire            wb_cyc,
	input  wire            wb_stb,
	input  wire            wb_we,
	input  wire reg_addr_t wb_adr,
	input  wire word_t     wb_dat_w,
	output word_t          wb_dat_r,
	output logic           wb_ack,
	output color_t         background_color,
	output coord_t         beam_x,
	output coord_t         beam_y,
	output logic           frame_start,
	output coord_t         display_x_out,
	output coord_t         display_y_out
);

	raster_if rif ();

	list_pc_t  pc;
	word_t     ins;
	logic      list_we;
	list_pc_t  list_waddr;
	word_t     list_wdata;
	logic      cop_we;
	reg_addr_t cop_addr;
	word_t     cop_data;
	logic      bg_we;
	color_t    bg_color;
	logic      copper_en;

	// Raster exposed for host synchronisation
	assign beam_x      = rif.x;
	assign beam_y      = rif.y;
	assign frame_start = rif.frame_tick;

	raster_timer u_raster_timer (
		.CLK  (CLK),
		.RSTb (RSTb),
		.rif  (rif)
	);

	copper_list_ram u_copper_list_ram (
		.CLK   (CLK),
		.raddr (pc),
		.rdata (ins),
		.we    (list_we),
		.waddr (list_waddr),
		.wdata (list_wdata)
	);

	copper_seq u_copper_seq (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.rif       (rif),
		.copper_en (copper_en),
		.pc        (pc),
		.ins       (ins),
		.cop_we    (cop_we),
		.cop_addr  (cop_addr),
		.cop_data  (cop_data),
		.bg_we     (bg_we),
		.bg_color  (bg_color)
	);

	gfx_regs u_gfx_regs (
		.CLK              (CLK),
		.RSTb             (RSTb),
		.wb_cyc           (wb_cyc),
		.wb_stb           (wb_stb),
		.wb_we            (wb_we),
		.wb_adr           (wb_adr),
		.wb_dat_w         (wb_dat_w),
		.wb_dat_r         (wb_dat_r),
		.wb_ack           (wb_ack),
		.list_we          (list_we),
		.list_waddr       (list_waddr),
		.list_wdata       (list_wdata),
		.cop_we           (cop_we),
		.cop_addr         (cop_addr),
		.cop_data         (cop_data),
		.bg_we            (bg_we),
		.bg_color_in      (bg_color),
		.rif              (rif),
		.copper_en        (copper_en),
		.background_color (background_color),
		.display_x_out    (display_x_out),
		.display_y_out    (display_y_out)
	);

endmodule

`default_nettype wire

// ==== gfx_copper_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module gfx_copper_assert import copper_pkg::*; (
	input wire         CLK,
	input wire         RSTb,
	input wire         ack,
	input wire         cyc,
	input wire         stb,
	input wire         cop_we,
	input wire         frame_tick,
	input wire coord_t x,
	input wire coord_t y
);

	// Single-cycle ack, only inside a request
	ack_with_stb: assert property (@(posedge CLK) disable iff (!RSTb) ack |-> (cyc && stb))
		else $error("ack without an active request");
	ack_one_cycle: assert property (@(posedge CLK) disable iff (!RSTb) ack |=> !ack)
		else $error("ack longer than one cycle");

	cop_we_pulse: assert property (@(posedge CLK) disable iff (!RSTb) cop_we |=> !cop_we)
		else $error("cop_we high two cycles running");

	frame_at_origin: assert property (@(posedge CLK) disable iff (!RSTb)
		frame_tick |-> (x == 0 && y == 0))
		else $error("frame_tick away from the origin");

endmodule

bind gfx_regs gfx_copper_assert u_regs_assert (
	.CLK        (CLK),
	.RSTb       (RSTb),
	.ack        (wb_ack),
	.cyc        (wb_cyc),
	.stb        (wb_stb),
	.cop_we     (cop_we),
	.frame_tick (rif.frame_tick),
	.x          (rif.x),
	.y          (rif.y)
);

`default_nettype wire

// ==== tb_gfx_copper.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gfx_copper import copper_pkg::*; ();

	typedef enum logic [2:0] {
		ACT_WRITE,
		ACT_READ,
		ACT_LIST,
		ACT_LINE,
		ACT_CHECK
	} act_e;

	typedef struct packed {
		act_e      act;
		reg_addr_t addr;
		word_t     data;
		word_t     exp;
	} row_t;

	localparam int FRAME_CYCLES = 40 * 30;

	logic      CLK;
	logic      RSTb;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	reg_addr_t wb_adr;
	word_t     wb_dat_w;
	word_t     wb_dat_r;
	logic      wb_ack;
	color_t    background_color;
	coord_t    beam_x;
	coord_t    beam_y;
	logic      frame_start;
	coord_t    display_x_out;
	coord_t    display_y_out;

	row_t        rows[$];
	logic        table_ready;
	logic [31:0] rng_state;

	// Reference register state
	logic   m_vflip;
	coord_t m_pan_x;
	coord_t m_pan_y;

	// Cycles since reset release, the beam position follows from it
	int unsigned beam_cnt;

	gfx_copper_top DUT (
		.CLK              (CLK),
		.RSTb             (RSTb),
		.wb_cyc           (wb_cyc),
		.wb_stb           (wb_stb),
		.wb_we            (wb_we),
		.wb_adr           (wb_adr),
		.wb_dat_w         (wb_dat_w),
		.wb_dat_r         (wb_dat_r),
		.wb_ack           (wb_ack),
		.background_color (background_color),
		.beam_x           (beam_x),
		.beam_y           (beam_y),
		.frame_start      (frame_start),
		.display_x_out    (display_x_out),
		.display_y_out    (display_y_out)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		if (!RSTb)
			beam_cnt <= 0;
		else
			beam_cnt <= beam_cnt + 1;
	end

	function automatic logic [31:0] xorshift();
		logic [31:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng_state = s;
		return s;
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic add_row(input act_e act, input reg_addr_t addr, input word_t data,
			input word_t exp);
		row_t r;
		r.act  = act;
		r.addr = addr;
		r.data = data;
		r.exp  = exp;
		rows.push_back(r);
	endtask

	task automatic update_model(input reg_addr_t adr, input word_t val);
		case (adr)
			REG_VFLIP:     m_vflip = val[0];
			REG_PAN_X:     m_pan_x = val[9:0];
			REG_PAN_Y:     m_pan_y = val[9:0];
			default: ;
		endcase
	endtask

	// Display x is registered, so it shows the previous beam x plus pan
	function automatic coord_t exp_disp_x(input coord_t bx);
		coord_t prev;
		prev = (bx == 0) ? H_TOTAL - 10'd1 : bx - 10'd1;
		return prev + m_pan_x;
	endfunction

	// Display y follows the line whose start was last seen
	function automatic coord_t exp_disp_y(input coord_t bx, input coord_t by);
		coord_t line;
		coord_t src;
		line = by;
		if (bx == 0)
			line = (by == 0) ? V_TOTAL - 10'd1 : by - 10'd1;
		src = m_vflip ? (V_TOTAL - 10'd1 - line) : line;
		return src + m_pan_y;
	endfunction

	// Called and returning 1 ns after a rising edge
	task automatic bus_cycle(input logic we, input reg_addr_t adr, input word_t wdat,
			output word_t rdat);
		int waited;
		waited   = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		do begin
			@(posedge CLK);
			#1;
			waited++;
		end while (!wb_ack && waited < 4);
		if (!wb_ack) begin
			$display("TEST FAILED");
			$fatal(1, "no bus acknowledge within 4 cycles");
		end
		check_value("wb_ack latency", 16'(waited), 16'd1);
		rdat = wb_dat_r;
		// Hold the request through the ack cycle
		@(posedge CLK);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wait_line(input coord_t line);
		int n;
		n = 0;
		while (!(beam_y == line && beam_x == 0)) begin
			@(posedge CLK);
			#1;
			n++;
			if (n > 2 * FRAME_CYCLES) begin
				$display("TEST FAILED");
				$fatal(1, "beam never reached the requested line");
			end
		end
	endtask

	task automatic run_row(input row_t r);
		word_t rd;
		case (r.act)
			ACT_WRITE: begin
				bus_cycle(1'b1, r.addr, r.data, rd);
				update_model(r.addr, r.data);
			end
			ACT_READ: begin
				bus_cycle(1'b0, r.addr, 16'h0, rd);
				check_value("wb_dat_r", rd, r.exp);
				update_model(r.addr, r.exp);
			end
			ACT_LIST: begin
				bus_cycle(1'b1, LIST_BASE + r.addr, r.data, rd);
			end
			ACT_LINE: begin
				wait_line(r.addr[9:0]);
			end
			default: begin
				check_value("beam_x", 16'(beam_x), 16'(beam_cnt % H_TOTAL));
				check_value("beam_y", 16'(beam_y), 16'((beam_cnt / H_TOTAL) % V_TOTAL));
				check_value("frame_start", 16'(frame_start),
					16'(beam_cnt % FRAME_CYCLES == 0));
				check_value("background_color", 16'(background_color), r.exp);
				check_value("display_x_out", 16'(display_x_out), 16'(exp_disp_x(beam_x)));
				check_value("display_y_out", 16'(display_y_out),
					16'(exp_disp_y(beam_x, beam_y)));
			end
		endcase
	endtask

	task automatic build_table();
		word_t r;
		r = word_t'(xorshift() & 32'h3FF);
		// Reset values
		add_row(ACT_LINE, 12'd2, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'hF00);
		add_row(ACT_READ, REG_COPPER_EN, 0, 16'h0);
		add_row(ACT_READ, REG_VFLIP, 0, 16'h0);
		add_row(ACT_READ, REG_BG_COLOR, 0, 16'hF00);
		add_row(ACT_READ, REG_PAN_X, 0, 16'h0);
		add_row(ACT_READ, REG_PAN_Y, 0, 16'h0);
		add_row(ACT_READ, 12'h123, 0, 16'h0);
		add_row(ACT_READ, 12'h400, 0, 16'h0);
		// Pan, flip and color from the host
		add_row(ACT_WRITE, REG_PAN_X, 16'h3FF, 0);
		add_row(ACT_WRITE, REG_PAN_Y, 16'h3FE, 0);
		add_row(ACT_WRITE, REG_VFLIP, 16'h1, 0);
		add_row(ACT_WRITE, REG_BG_COLOR, 16'h055, 0);
		add_row(ACT_READ, REG_PAN_X, 0, 16'h3FF);
		add_row(ACT_READ, REG_PAN_Y, 0, 16'h3FE);
		add_row(ACT_READ, REG_VFLIP, 0, 16'h1);
		add_row(ACT_READ, REG_BG_COLOR, 0, 16'h055);
		add_row(ACT_LINE, 12'd5, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h055);
		add_row(ACT_LINE, 12'd20, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h055);
		add_row(ACT_WRITE, REG_VFLIP, 16'h0, 0);
		add_row(ACT_WRITE, REG_PAN_X, 16'h0, 0);
		add_row(ACT_WRITE, REG_PAN_Y, 16'h0, 0);
		add_row(ACT_WRITE, REG_BG_COLOR, 16'hF00, 0);
		// Wait for line 5, then set the color
		add_row(ACT_LIST, 12'd0, 16'h2005, 0);
		add_row(ACT_LIST, 12'd1, 16'h60AB, 0);
		add_row(ACT_LIST, 12'd2, 16'h23FF, 0);
		add_row(ACT_LINE, 12'd0, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'hF00);
		add_row(ACT_WRITE, REG_COPPER_EN, 16'h1, 0);
		add_row(ACT_LINE, 12'd4, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'hF00);
		add_row(ACT_LINE, 12'd6, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h0AB);
		add_row(ACT_LINE, 12'd4, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h0AB);
		add_row(ACT_READ, REG_COPPER_EN, 0, 16'h1);
		add_row(ACT_LINE, 12'd8, 0, 0);
		// Copper writes pan_x
		add_row(ACT_LIST, 12'd0, 16'h9D23, 0);
		add_row(ACT_LIST, 12'd1, r, 0);
		add_row(ACT_LIST, 12'd2, 16'h23FF, 0);
		add_row(ACT_LINE, 12'd0, 0, 0);
		add_row(ACT_LINE, 12'd2, 0, 0);
		add_row(ACT_READ, REG_PAN_X, 0, r);
		add_row(ACT_LINE, 12'd3, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h0AB);
		add_row(ACT_LINE, 12'd15, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h0AB);
		// Skip at line 10, then a jump over later colors
		add_row(ACT_LIST, 12'd0, 16'h200A, 0);
		add_row(ACT_LIST, 12'd1, 16'h400A, 0);
		add_row(ACT_LIST, 12'd2, 16'h6111, 0);
		add_row(ACT_LIST, 12'd3, 16'h6222, 0);
		add_row(ACT_LIST, 12'd4, 16'h1006, 0);
		add_row(ACT_LIST, 12'd5, 16'h6333, 0);
		add_row(ACT_LIST, 12'd6, 16'h23FF, 0);
		add_row(ACT_LIST, 12'd7, 16'h6444, 0);
		add_row(ACT_LINE, 12'd9, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h0AB);
		add_row(ACT_LINE, 12'd11, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h222);
		add_row(ACT_LINE, 12'd25, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h222);
		// Relative wait of 3 lines from line 2
		add_row(ACT_LIST, 12'd0, 16'h2002, 0);
		add_row(ACT_LIST, 12'd1, 16'h7003, 0);
		add_row(ACT_LIST, 12'd2, 16'h65A5, 0);
		add_row(ACT_LIST, 12'd3, 16'h23FF, 0);
		add_row(ACT_LINE, 12'd4, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h222);
		add_row(ACT_LINE, 12'd5, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h222);
		add_row(ACT_LINE, 12'd6, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h5A5);
		// Disabled copper ignores the new list
		add_row(ACT_WRITE, REG_COPPER_EN, 16'h0, 0);
		add_row(ACT_READ, REG_COPPER_EN, 0, 16'h0);
		add_row(ACT_LIST, 12'd0, 16'h60F0, 0);
		add_row(ACT_LIST, 12'd2, 16'h60F0, 0);
		add_row(ACT_LINE, 12'd0, 0, 0);
		add_row(ACT_LINE, 12'd10, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h5A5);
		add_row(ACT_LINE, 12'd28, 0, 0);
		add_row(ACT_CHECK, 0, 0, 16'h5A5);
		add_row(ACT_READ, REG_BG_COLOR, 0, 16'h5A5);
	endtask

	initial begin
		wait (table_ready);
		repeat (rows.size() * 2 * FRAME_CYCLES) @(posedge CLK);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired before the table finished");
	end

	initial begin
		RSTb        = 1'b0;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_w    = '0;
		table_ready = 1'b0;
		rng_state   = 32'd79373;
		m_vflip     = 1'b0;
		m_pan_x     = '0;
		m_pan_y     = '0;
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge CLK);
		#1;
		RSTb = 1'b1;
		foreach (rows[i]) begin
			run_row(rows[i]);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
copper_pkg.sv
raster_if.sv
raster_timer.sv
copper_list_ram.sv
copper_seq.sv
gfx_regs.sv
gfx_copper_top.sv
gfx_copper_assert.sv
tb_gfx_copper.sv

// ==== Makefile ====
TOP = tb_gfx_copper

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
